//--- Makefile
# Verilator build and run for the fetch stage testbench
# override on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST ?= files.f
TOP ?= fetchStageTb
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps -j 0
PASS_TEXT ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/fetchStage.sv
module fetchStage (
    input logic clk,
    input logic rst_n,
    // hazard unit
    input logic stall,
    input logic clr,
    input logic stallPc,
    // ID stage
    input isaPkg::word_t idInstr,
    input logic cmp,
    input sysPkg::addr_t jumpReg,
    // coprocessor 0
    input sysPkg::kctrl_t kernelCtrl,
    input sysPkg::epc_t epc,
    // instruction memory
    output sysPkg::addr_t imAddr,
    input isaPkg::word_t imCode,
    // IF side
    output sysPkg::addr_t pcIf,
    output logic delaySlotIf,
    // IF/ID register
    output isaPkg::word_t idCode,
    output sysPkg::addr_t idPc,
    output sysPkg::excCode_t idExc,
    output logic idDelaySlot
);
    import isaPkg::*;
    import sysPkg::*;

    addr_t pc;
    addr_t nextPc;
    excCode_t pcExc;
    logic delaySlot;

    nextPcUnit npc (
        .pc(pc),
        .instr(idInstr),
        .cmp(cmp),
        .jumpReg(jumpReg),
        .kernelCtrl(kernelCtrl),
        .epc(epc),
        .nextPc(nextPc),
        .delaySlot(delaySlot)
    );

    // pc only advances while the hazard unit allows it
    pcReg pcRegister (
        .clk(clk),
        .rst_n(rst_n),
        .en(~stallPc),
        .nextPc(nextPc),
        .pc(pc),
        .exc(pcExc)
    );

    assign imAddr = pc;
    assign pcIf = pc;

    // word being fetched now sits in the delay slot of the ID instruction
    assign delaySlotIf = delaySlot;

    // IF/ID pipeline register, clear wins over stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idCode <= '0;
            idPc <= '0;
            idExc <= excNone;
            idDelaySlot <= 1'b0;
        end else if (clr) begin
            idCode <= '0;
            idPc <= '0;
            idExc <= excNone;
            idDelaySlot <= 1'b0;
        end else if (!stall) begin
            idCode <= imCode;
            idPc <= pc;
            idExc <= pcExc;
            idDelaySlot <= delaySlot;
        end
    end

endmodule

//--- design/instrClassifier.sv
module instrClassifier (
    input isaPkg::word_t instr,
    output isaPkg::instrClass_t instrClass
);
    import isaPkg::*;

    opcode_t opcode;
    funct_t funct;
    regIdx_t rt;

    assign opcode = instr[opcodeMsb:opcodeLsb];
    assign funct = instr[functMsb:functLsb];
    assign rt = instr[rtMsb:rtLsb];

    always_comb begin
        instrClass = classSeq;
        case (opcode)
            opSpecial: begin
                // only jr and jalr redirect among the special ops
                if (funct == functJr || funct == functJalr) begin
                    instrClass = classJumpReg;
                end
            end
            opRegImm: begin
                // bltz, bgez, bltzal, bgezal
                if (rt[3:1] == regImmBranchMid) begin
                    instrClass = classBranch;
                end
            end
            opJ, opJal: begin
                instrClass = classJumpImm;
            end
            opBeq, opBne, opBlez, opBgtz: begin
                instrClass = classBranch;
            end
            default: begin
                instrClass = classSeq;
            end
        endcase
    end

endmodule

//--- design/isaPkg.sv
package isaPkg;

    // instruction and data words
    typedef logic [31:0] word_t;

    // instruction fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;
    typedef logic [4:0] regIdx_t;
    typedef logic [15:0] imm_t;
    typedef logic [25:0] jumpIndex_t;

    // control-flow class of the instruction in ID
    typedef logic [1:0] instrClass_t;

    // field positions within an instruction word
    localparam int opcodeMsb = 31;
    localparam int opcodeLsb = 26;
    localparam int rtMsb = 20;
    localparam int rtLsb = 16;
    localparam int immMsb = 15;
    localparam int immLsb = 0;
    localparam int indexMsb = 25;
    localparam int indexLsb = 0;
    localparam int functMsb = 5;
    localparam int functLsb = 0;

    // primary opcodes
    localparam opcode_t opSpecial = 6'd0;
    localparam opcode_t opRegImm = 6'd1;
    localparam opcode_t opJ = 6'd2;
    localparam opcode_t opJal = 6'd3;
    localparam opcode_t opBeq = 6'd4;
    localparam opcode_t opBne = 6'd5;
    localparam opcode_t opBlez = 6'd6;
    localparam opcode_t opBgtz = 6'd7;

    // funct codes under opSpecial
    localparam funct_t functJr = 6'd8;
    localparam funct_t functJalr = 6'd9;

    // regimm branches sit at rt 0, 1, 16 and 17; the traps use rt 8 to 14
    localparam logic [2:0] regImmBranchMid = 3'b000;

    // control-flow classes
    localparam instrClass_t classSeq = 2'd0;
    localparam instrClass_t classBranch = 2'd1;
    localparam instrClass_t classJumpImm = 2'd2;
    localparam instrClass_t classJumpReg = 2'd3;

endpackage

//--- design/nextPcUnit.sv
module nextPcUnit (
    input sysPkg::addr_t pc,
    input isaPkg::word_t instr,
    input logic cmp,
    input sysPkg::addr_t jumpReg,
    input sysPkg::kctrl_t kernelCtrl,
    input sysPkg::epc_t epc,
    output sysPkg::addr_t nextPc,
    output logic delaySlot
);
    import isaPkg::*;
    import sysPkg::*;

    instrClass_t instrClass;
    imm_t imm16;
    jumpIndex_t jumpIndex;
    addr_t branchOffset;
    addr_t branchTarget;
    addr_t jumpTarget;
    addr_t seqPc;
    logic programEnd;

    instrClassifier classifier (
        .instr(instr),
        .instrClass(instrClass)
    );

    assign imm16 = instr[immMsb:immLsb];
    assign jumpIndex = instr[indexMsb:indexLsb];

    // offset is relative to the delay-slot pc, which is the current fetch pc
    assign branchOffset = {{14{imm16[15]}}, imm16, 2'b00};
    assign branchTarget = pc + branchOffset;

    // region bits come from the delay-slot pc
    assign jumpTarget = {pc[31:28], jumpIndex, 2'b00};

    assign seqPc = pc + 32'd4;

    // last word before the handler marks the end of the user program
    assign programEnd = (pc == kernelStart - 32'd4);

    // taken or not, the next fetch after a branch is its delay slot
    assign delaySlot = (instrClass != classSeq);

    always_comb begin
        if (kernelCtrl == kctrlKernelEntry) begin
            nextPc = kernelStart;
        end else if (kernelCtrl == kctrlEret) begin
            nextPc = {epc, 2'b00};
        end else if (programEnd) begin
            nextPc = pc;
        end else begin
            case (instrClass)
                classJumpReg: begin
                    nextPc = jumpReg;
                end
                classJumpImm: begin
                    nextPc = jumpTarget;
                end
                classBranch: begin
                    nextPc = cmp ? branchTarget : seqPc;
                end
                default: begin
                    nextPc = seqPc;
                end
            endcase
        end
    end

endmodule

//--- design/pcReg.sv
module pcReg (
    input logic clk,
    input logic rst_n,
    input logic en,
    input sysPkg::addr_t nextPc,
    output sysPkg::addr_t pc,
    output sysPkg::excCode_t exc
);
    import sysPkg::*;

    logic outOfText;
    logic misaligned;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= textStart;
        end else if (en) begin
            pc <= nextPc;
        end
    end

    // fetch address checks
    assign outOfText = (pc < textStart) || (pc >= textEnd);
    assign misaligned = (pc[1:0] != 2'b00);

    assign exc = (outOfText || misaligned) ? excAdEL : excNone;

endmodule

//--- design/sysPkg.sv
package sysPkg;

    // byte address
    typedef logic [31:0] addr_t;

    // word address, bits 31 to 2 of a byte address
    typedef logic [29:0] epc_t;

    // exception code, bits 6 to 2 of the cause field
    typedef logic [4:0] excCode_t;

    // kernel control from coprocessor 0
    typedef logic [1:0] kctrl_t;

    // address map
    localparam addr_t textStart = 32'h0000_3000;
    // exclusive upper bound of the fetchable region
    localparam addr_t textEnd = 32'h0000_5000;
    localparam addr_t kernelStart = 32'h0000_4180;

    // exception codes
    localparam excCode_t excNone = 5'd0;
    // address error on load or fetch
    localparam excCode_t excAdEL = 5'd4;

    // kernel control codes
    localparam kctrl_t kctrlNone = 2'd0;
    localparam kctrl_t kctrlKernelEntry = 2'd1;
    localparam kctrl_t kctrlEret = 2'd2;

endpackage

//--- files.f
design/isaPkg.sv
design/sysPkg.sv
design/instrClassifier.sv
design/nextPcUnit.sv
design/pcReg.sv
design/fetchStage.sv
testbench/fetchStage_asserts.sv
testbench/fetchStageTb.sv

//--- testbench/fetchStageTb.sv
module fetchStageTb;
    timeunit 1ns;
    timeprecision 100ps;

    import isaPkg::*;
    import sysPkg::*;

    localparam int clkPeriod = 10;
    localparam int resetCycles = 8;
    localparam int numCycles = 2000;
    localparam int timeoutNs = 2 * numCycles * clkPeriod;

    logic clk = 1'b0;
    logic rst_n;
    logic stall;
    logic clr;
    logic stallPc;
    word_t idInstr;
    logic cmp;
    addr_t jumpReg;
    kctrl_t kernelCtrl;
    epc_t epc;
    addr_t imAddr;
    word_t imCode;
    addr_t pcIf;
    logic delaySlotIf;
    word_t idCode;
    addr_t idPc;
    excCode_t idExc;
    logic idDelaySlot;

    logic [31:0] rngState = 32'hbd8930cb;
    int checkedCycles = 0;

    // model of the PC and the IF/ID register
    addr_t modelPc;
    word_t modelCode;
    addr_t modelIdPc;
    excCode_t modelExc;
    logic modelDs;

    fetchStage dut (
        .clk(clk),
        .rst_n(rst_n),
        .stall(stall),
        .clr(clr),
        .stallPc(stallPc),
        .idInstr(idInstr),
        .cmp(cmp),
        .jumpReg(jumpReg),
        .kernelCtrl(kernelCtrl),
        .epc(epc),
        .imAddr(imAddr),
        .imCode(imCode),
        .pcIf(pcIf),
        .delaySlotIf(delaySlotIf),
        .idCode(idCode),
        .idPc(idPc),
        .idExc(idExc),
        .idDelaySlot(idDelaySlot)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic logic [31:0] nextRandom();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        // fold the high half into the short-period low bits
        return rngState ^ (rngState >> 16);
    endfunction

    // instruction memory returns a hash of the full address
    function automatic word_t memHash(input addr_t a);
        word_t h;
        h = a * 32'h9e3779b1;
        return h ^ {a[15:0], a[31:16]} ^ 32'h5bd1e995;
    endfunction

    assign imCode = memHash(imAddr);

    function automatic instrClass_t refClass(input word_t instr);
        logic [5:0] op;
        logic [5:0] fn;
        logic [4:0] rt;
        logic regImmBranch;
        op = instr[31:26];
        fn = instr[5:0];
        rt = instr[20:16];
        regImmBranch = (rt == 5'd0 || rt == 5'd1 || rt == 5'd16 || rt == 5'd17);
        if (op == opSpecial && (fn == functJr || fn == functJalr)) begin
            return classJumpReg;
        end else if (op == opRegImm && regImmBranch) begin
            return classBranch;
        end else if (op == opJ || op == opJal) begin
            return classJumpImm;
        end else if (op == opBeq || op == opBne || op == opBlez || op == opBgtz) begin
            return classBranch;
        end
        return classSeq;
    endfunction

    function automatic excCode_t refExc(input addr_t pc);
        if (pc < textStart || pc >= textEnd || pc[1:0] != 2'b00) begin
            return excAdEL;
        end
        return excNone;
    endfunction

    function automatic addr_t expectedNextPc(input addr_t pc, input word_t instr,
            input logic taken, input addr_t regTarget, input kctrl_t kctrl,
            input epc_t epcWord);
        instrClass_t cls;
        addr_t offset;
        cls = refClass(instr);
        offset = {{14{instr[15]}}, instr[15:0], 2'b00};
        if (kctrl == kctrlKernelEntry) begin
            return kernelStart;
        end else if (kctrl == kctrlEret) begin
            return {epcWord, 2'b00};
        end else if (pc == kernelStart - 32'd4) begin
            return pc;
        end else if (cls == classJumpReg) begin
            return regTarget;
        end else if (cls == classJumpImm) begin
            return {pc[31:28], instr[25:0], 2'b00};
        end else if (cls == classBranch && taken) begin
            return pc + offset;
        end
        return pc + 32'd4;
    endfunction

    function automatic word_t makeInstr(input logic [31:0] r);
        imm_t imm;
        addr_t target;
        regIdx_t rt;
        imm = {{10{r[21]}}, r[21:16]};
        target = textStart + {19'd0, r[12:2], 2'b00};
        rt = {r[2], 3'b000, r[3]};
        case (r[31:29])
            3'd0: return {opSpecial, r[25:6], 6'h21};
            // opcodes 8 to 39 never redirect
            3'd1: return {6'd8 + {1'b0, r[4:0]}, r[25:0]};
            3'd2: return {4'b0001, r[1:0], r[25:16], imm};
            3'd3: return {opRegImm, r[25:21], rt, imm};
            3'd4: return {5'b00001, r[0], target[27:2]};
            3'd5: return {opSpecial, r[25:21], 5'd0, r[15:11], 5'd0, r[6] ? functJalr : functJr};
            // regimm traps stay sequential
            3'd6: return {opRegImm, r[25:21], 2'b01, r[7:5], imm};
            default: return {opSpecial, r[25:11], 5'd0, 6'h2a};
        endcase
    endfunction

    // mostly aligned text addresses with some misaligned or outside text
    function automatic addr_t makeRegTarget(input logic [31:0] r);
        addr_t base;
        base = textStart + {19'd0, r[12:2], 2'b00};
        case (r[15:13])
            3'd0: return base | 32'd1;
            3'd1: return textEnd + {20'd0, r[11:2], 2'b00};
            3'd2: return {20'h00001, r[11:0]};
            default: return base;
        endcase
    endfunction

    function automatic epc_t makeEpc(input logic [31:0] r);
        addr_t epcAddr;
        epcAddr = textStart + {19'd0, r[12:2], 2'b00};
        // return straight to the program end now and then
        if (r[1:0] == 2'b00) begin
            epcAddr = kernelStart - 32'd4;
        end
        return epcAddr[31:2];
    endfunction

    task automatic checkAddr(input string name, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            $display("error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
            $display("tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic checkWord(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
            $display("tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic checkExc(input string name, input excCode_t expected,
            input excCode_t actual);
        if (actual !== expected) begin
            $display("error at %0t ns: %s expected %0d, actual %0d",
                $time, name, expected, actual);
            $display("tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error at %0t ns: %s expected %b, actual %b", $time, name, expected, actual);
            $display("tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // stimulus driven on the rising edge
    initial begin
        logic [31:0] r;
        logic [31:0] s;
        rst_n = 1'b0;
        stall = 1'b0;
        clr = 1'b0;
        stallPc = 1'b0;
        idInstr = '0;
        cmp = 1'b0;
        jumpReg = '0;
        kernelCtrl = kctrlNone;
        epc = '0;
        repeat (resetCycles) @(posedge clk);
        rst_n <= 1'b1;
        repeat (numCycles) begin
            @(posedge clk);
            r = nextRandom();
            s = nextRandom();
            idInstr <= makeInstr(r);
            cmp <= s[0];
            jumpReg <= makeRegTarget(nextRandom());
            epc <= makeEpc(nextRandom());
            if (s[15:8] < 8'd4) begin
                kernelCtrl <= kctrlKernelEntry;
            end else if (s[15:8] < 8'd8) begin
                kernelCtrl <= kctrlEret;
            end else begin
                kernelCtrl <= kctrlNone;
            end
            stall <= (s[19:16] == 4'd0);
            stallPc <= (s[23:20] == 4'd0);
            clr <= (s[28:24] == 5'd0);
        end
        repeat (2) @(posedge clk);
        if (dut.checks.failCount != 0) begin
            $display("%0d assertion failures during the run", dut.checks.failCount);
            $display("tests failed");
            $fatal(1, "assertion failures");
        end else begin
            $display("checked %0d cycles", checkedCycles);
            $display("all tests passed");
            $finish;
        end
    end

    // compare on the falling edge and then step the model
    initial begin
        modelPc = textStart;
        modelCode = '0;
        modelIdPc = '0;
        modelExc = excNone;
        modelDs = 1'b0;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            checkAddr("pcIf", modelPc, pcIf);
            checkAddr("imAddr", modelPc, imAddr);
            checkBit("delaySlotIf", refClass(idInstr) != classSeq, delaySlotIf);
            checkWord("idCode", modelCode, idCode);
            checkAddr("idPc", modelIdPc, idPc);
            checkExc("idExc", modelExc, idExc);
            checkBit("idDelaySlot", modelDs, idDelaySlot);
            if (clr) begin
                modelCode = '0;
                modelIdPc = '0;
                modelExc = excNone;
                modelDs = 1'b0;
            end else if (!stall) begin
                modelCode = memHash(modelPc);
                modelIdPc = modelPc;
                modelExc = refExc(modelPc);
                modelDs = (refClass(idInstr) != classSeq);
            end
            if (!stallPc) begin
                modelPc = expectedNextPc(modelPc, idInstr, cmp, jumpReg, kernelCtrl, epc);
            end
            checkedCycles++;
        end
    end

    initial begin
        #(timeoutNs);
        $display("error: the run timed out after %0d ns without finishing", timeoutNs);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- testbench/fetchStage_asserts.sv
module fetchStageAsserts (
    input logic clk,
    input logic rst_n,
    input logic stallPc,
    input logic clr,
    input sysPkg::addr_t pcIf,
    input logic delaySlotIf,
    input isaPkg::word_t idCode,
    input sysPkg::addr_t idPc,
    input sysPkg::excCode_t idExc,
    input logic idDelaySlot
);
    timeunit 1ns;
    timeprecision 100ps;

    import sysPkg::*;

    // failures so far, read by the testbench at the end of the run
    int failCount = 0;

    // pc frozen while the hazard unit holds it
    pcHoldCheck: assert property (@(posedge clk) disable iff (!rst_n)
        stallPc |=> $stable(pcIf))
    else begin
        failCount = failCount + 1;
        $error("pcIf changed across an edge with stallPc high");
    end

    // clear empties the IF/ID register
    clearCheck: assert property (@(posedge clk) disable iff (!rst_n)
        clr |=> (idCode == '0 && idPc == '0 && idExc == excNone && !idDelaySlot))
    else begin
        failCount = failCount + 1;
        $error("IF/ID outputs not zero after an edge with clr high");
    end

    knownSlotCheck: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(delaySlotIf))
    else begin
        failCount = failCount + 1;
        $error("delaySlotIf is unknown");
    end

endmodule

bind fetchStage fetchStageAsserts checks (
    .clk(clk),
    .rst_n(rst_n),
    .stallPc(stallPc),
    .clr(clr),
    .pcIf(pcIf),
    .delaySlotIf(delaySlotIf),
    .idCode(idCode),
    .idPc(idPc),
    .idExc(idExc),
    .idDelaySlot(idDelaySlot)
);
